/* Bender.yml */
package:
  name: snake

sources:
  - files:
      - src/snakePkg.sv
      - src/snakeBody.sv
      - src/snakeGrowth.sv
      - src/snakeCollision.sv
      - src/snakeIconRender.sv
      - src/snakeTop.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/snakeTopTb.sv

/* sim.f */
+incdir+verif
src/snakePkg.sv
src/snakeBody.sv
src/snakeGrowth.sv
src/snakeCollision.sv
src/snakeIconRender.sv
src/snakeTop.sv
verif/snakeTopTb.sv

/* src/snakeBody.sv */
module snakeBody
#(
	parameter int maxLength = 100 // highest segment index
)
(
	input logic Clock,
	input logic rstN,
	input logic ctrlOff,
	input logic iconTick,
	input snakePkg::coordT locationX,
	input snakePkg::coordT locationY,
	input snakePkg::lengthT snakeLength,
	output snakePkg::segmentT body [0:maxLength],
	output logic moved
);

	import snakePkg::*;

	logic step; // counted move tick

	// frozen while the game is switched off
	assign step = iconTick & ~ctrlOff;

	// segment 0 is the head, loaded straight from the location inputs
	// the rest of the stack shifts one place per move
	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			body[0] <= {startX, startY};
			for (int i = 1; i <= maxLength; i++)
			begin
				if (i <= startLength)
					body[i] <= {coordT'(startX - i), startY}; // straight line behind head
				else
					body[i] <= '0;
			end
		end
		else if (step)
		begin
			body[0] <= {locationX, locationY}; // new head
			for (int i = 1; i <= maxLength; i++)
			begin
				// length here is still the one from before any growth
				if (i <= snakeLength)
					body[i] <= body[i-1];
				else
					body[i] <= '0; // past the tail
			end
		end
	end

	// one pulse after the shift lands, starts the collision check
	always_ff @(posedge Clock)
	begin
		if (!rstN)
			moved <= 1'b0;
		else
			moved <= step;
	end

endmodule

/* src/snakeCollision.sv */
module snakeCollision
#(
	parameter int maxLength = 100
)
(
	input logic Clock,
	input logic rstN,
	input logic moved,
	input snakePkg::segmentT body [0:maxLength],
	input snakePkg::lengthT snakeLength,
	output logic gameOver
);

	import snakePkg::*;

	logic wallHit;
	logic winHit;
	logic selfHit;
	segmentT head;

	assign head = body[0];

	// walls count as hit when touched, not only when crossed
	assign wallHit = (head.x <= xMin) || (head.x >= xMax) ||
		(head.y <= yMin) || (head.y >= yMax);

	assign winHit = (snakeLength >= winLength); // long enough, player wins

	// head against every live segment
	always_comb
	begin
		selfHit = 1'b0;
		for (int i = 1; i <= maxLength; i++)
		begin
			if ((i <= snakeLength) && (body[i] == head))
				selfHit = 1'b1; // OR over the whole body
		end
	end

	// evaluated once per move, level held in between
	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			gameOver <= 1'b0;
		end
		else if (moved)
		begin
			gameOver <= wallHit | winHit | selfHit;
		end
	end

endmodule

/* src/snakeGrowth.sv */
module snakeGrowth
(
	input logic Clock,
	input logic rstN,
	input logic ctrlOff,
	input logic iconTick,
	input snakePkg::coordT locationX,
	input snakePkg::coordT locationY,
	input snakePkg::coordT foodX,
	input snakePkg::coordT foodY,
	output snakePkg::lengthT snakeLength,
	output logic foodGen
);

	import snakePkg::*;

	levelT level;
	levelT levelNext;
	lengthT lengthNext;
	logic step;
	logic eat;

	assign step = iconTick & ~ctrlOff;
	// head lands on the food on this move
	assign eat = step && ({locationX, locationY} == {foodX, foodY});

	// level FSM, advances only on an eat at the exact threshold
	always_comb
	begin
		levelNext = level;
		lengthNext = snakeLength + 8'd1; // normal growth
		case (level)
			levelOne:
			begin
				if (snakeLength == levelOneEnd)
				begin
					levelNext = levelTwo;
					lengthNext = levelTwoStart; // jump, not +1
				end
			end
			levelTwo:
			begin
				if (snakeLength == levelTwoEnd)
				begin
					levelNext = levelThree;
					lengthNext = levelThreeStart;
				end
			end
			default:
			begin
				levelNext = levelThree; // last level, stays
			end
		endcase
	end

	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			level <= levelOne;
			snakeLength <= startLength;
			foodGen <= 1'b1; // ask for the first food during reset
		end
		else
		begin
			foodGen <= eat; // one cycle request per eat
			if (eat)
			begin
				level <= levelNext;
				snakeLength <= lengthNext;
			end
		end
	end

endmodule

/* src/snakeIconRender.sv */
module snakeIconRender
#(
	parameter int maxLength = 100
)
(
	input logic Clock,
	input logic rstN,
	input snakePkg::coordT pixelRow,
	input snakePkg::coordT pixelCol,
	input snakePkg::segmentT body [0:maxLength],
	input snakePkg::lengthT snakeLength,
	output snakePkg::iconT icon
);

	import snakePkg::*;

	logic bodyHit;
	segmentT pixel;

	// pixel in the same x then y order as a segment
	assign pixel = {pixelRow, pixelCol};

	// parallel compare, head included
	always_comb
	begin
		bodyHit = 1'b0;
		for (int i = 0; i <= maxLength; i++)
		begin
			if ((i <= snakeLength) && (body[i] == pixel))
				bodyHit = 1'b1;
		end
	end

	// one cycle behind the pixel scan
	always_ff @(posedge Clock)
	begin
		if (!rstN)
			icon <= iconNone;
		else if (bodyHit)
			icon <= iconBody;
		else
			icon <= iconNone; // colorizer falls through to lower layers
	end

endmodule

/* src/snakePkg.sv */
package snakePkg;

	// screen coordinate, one axis
	typedef logic [10:0] coordT;

	// one body segment, x in the upper half
	typedef struct packed
	{
		coordT x;
		coordT y;
	} segmentT;

	typedef logic [7:0] lengthT; // segment count past the head

	// arena walls, touching one ends the game
	parameter coordT xMin = 11'd212;
	parameter coordT xMax = 11'd469;
	parameter coordT yMin = 11'd112;
	parameter coordT yMax = 11'd368;

	// start pose inside the arena
	parameter coordT startX = 11'd240;
	parameter coordT startY = 11'd240;
	parameter lengthT startLength = 8'd20; // body trails in minus x

	// level thresholds
	parameter lengthT levelOneEnd = 8'd27; // eat here jumps to level two
	parameter lengthT levelTwoEnd = 8'd60; // eat here jumps to level three
	parameter lengthT levelTwoStart = 8'd50;
	parameter lengthT levelThreeStart = 8'd85;
	parameter lengthT winLength = 8'd95; // reaching this ends the game as a win

	typedef enum logic [1:0]
	{
		levelOne,
		levelTwo,
		levelThree
	} levelT;

	// codes seen by the colorizer
	typedef enum logic [2:0]
	{
		iconNone = 3'd0, // background, lowest priority
		iconBody = 3'd1
	} iconT;

endpackage

/* src/snakeTop.sv */
module snakeTop
#(
	parameter int maxLength = 100 // must be at least the win length
)
(
	input logic Clock,
	input logic rstN,
	input logic ctrlOff,
	input logic iconTick,
	input snakePkg::coordT pixelRow,
	input snakePkg::coordT pixelCol,
	input snakePkg::coordT locationX,
	input snakePkg::coordT locationY,
	input snakePkg::coordT foodX,
	input snakePkg::coordT foodY,
	output snakePkg::iconT icon,
	output snakePkg::lengthT snakeLength,
	output logic gameOver,
	output logic foodGen
);

	import snakePkg::*;

	segmentT body [0:maxLength]; // shared segment stack
	logic moved; // shift done, check collisions

	// stack of segments, shifts on each counted tick
	snakeBody #(
		.maxLength(maxLength)
	) i_snakeBody (
		.Clock(Clock),
		.rstN(rstN),
		.ctrlOff(ctrlOff),
		.iconTick(iconTick),
		.locationX(locationX),
		.locationY(locationY),
		.snakeLength(snakeLength),
		.body(body),
		.moved(moved)
	);

	// length, level and food request
	snakeGrowth i_snakeGrowth (
		.Clock(Clock),
		.rstN(rstN),
		.ctrlOff(ctrlOff),
		.iconTick(iconTick),
		.locationX(locationX),
		.locationY(locationY),
		.foodX(foodX),
		.foodY(foodY),
		.snakeLength(snakeLength),
		.foodGen(foodGen)
	);

	// game over two cycles after the tick
	snakeCollision #(
		.maxLength(maxLength)
	) i_snakeCollision (
		.Clock(Clock),
		.rstN(rstN),
		.moved(moved),
		.body(body),
		.snakeLength(snakeLength),
		.gameOver(gameOver)
	);

	snakeIconRender #(
		.maxLength(maxLength)
	) i_snakeIconRender (
		.Clock(Clock),
		.rstN(rstN),
		.pixelRow(pixelRow),
		.pixelCol(pixelCol),
		.body(body),
		.snakeLength(snakeLength),
		.icon(icon)
	);

endmodule

/* verif/snakeTbTable.svh */
// columns: name, action, steps, x, y, food on head, food x, food y,
// then expected length, foodGen, gameOver, icon
// x and y are the pixel on a probe, x steps by one across a run
task automatic loadTable();
	// reset state
	addRow("resetState", actReset, 1, 0, 0, 0, 0, 0, 20, 0, 0, 0);

	// one step right, no food
	addRow("moveRight", actTick, 1, 241, 240, 0, 300, 300, 20, 0, 0, 0);
	addRow("probeHead", actProbe, 1, 241, 240, 0, 0, 0, 0, 0, 0, 1);
	addRow("probeNewTail", actProbe, 1, 221, 240, 0, 0, 0, 0, 0, 0, 1);
	addRow("probeOldTail", actProbe, 1, 220, 240, 0, 0, 0, 0, 0, 0, 0); // old segment 20

	// switched off, food under the head is ignored
	addRow("frozenEat", actFrozen, 1, 242, 240, 0, 242, 240, 20, 0, 0, 0);
	addRow("probeFrozenHead", actProbe, 1, 242, 240, 0, 0, 0, 0, 0, 0, 0);
	addRow("probeStillHead", actProbe, 1, 241, 240, 0, 0, 0, 0, 0, 0, 1);
	addRow("randomMiss", actRandom, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0);

	// eating through the levels
	addRow("eatRun", actTick, 7, 242, 240, 1, 0, 0, 27, 1, 0, 0);
	addRow("jumpLevelTwo", actTick, 1, 249, 240, 1, 0, 0, 50, 1, 0, 0);
	addRow("probeEatenHead", actProbe, 1, 249, 240, 0, 0, 0, 0, 0, 0, 1);
	addRow("eatToSixty", actTick, 10, 250, 240, 1, 0, 0, 60, 1, 0, 0);
	addRow("jumpLevelThree", actTick, 1, 260, 240, 1, 0, 0, 85, 1, 0, 0);
	addRow("eatToWin", actTick, 10, 261, 240, 1, 0, 0, 95, 1, 1, 0); // win length

	// right wall
	addRow("resetForWall", actReset, 1, 0, 0, 0, 0, 0, 20, 0, 0, 0);
	addRow("hitWall", actTick, 1, 469, 240, 0, 300, 300, 20, 0, 1, 0);

	// small square back into the body, head meets segment 4
	addRow("resetForSquare", actReset, 1, 0, 0, 0, 0, 0, 20, 0, 0, 0);
	addRow("squareUp", actTick, 1, 240, 241, 0, 300, 300, 20, 0, 0, 0);
	addRow("squareLeft", actTick, 1, 239, 241, 0, 300, 300, 20, 0, 0, 0);
	addRow("squareDown", actTick, 1, 239, 240, 0, 300, 300, 20, 0, 1, 0);
	addRow("probeAway", actProbe, 1, 400, 300, 0, 0, 0, 0, 0, 0, 0);
	addRow("randomAfterHit", actRandom, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0);
endtask

/* verif/snakeTopTb.sv */
module snakeTopTb;

	timeunit 1ns;
	timeprecision 1ps;

	import snakePkg::*;

	// what a table row does
	typedef enum {actReset, actTick, actFrozen, actProbe, actRandom} actT;

	localparam int maxRows = 64;
	localparam int modelMax = 100; // same as the DUT default maxLength
	localparam int periodNs = 40;

	logic Clock;
	logic rstN;
	logic ctrlOff;
	logic iconTick;
	coordT pixelRow;
	coordT pixelCol;
	coordT locationX;
	coordT locationY;
	coordT foodX;
	coordT foodY;
	iconT icon;
	lengthT snakeLength;
	logic gameOver;
	logic foodGen;

	// table columns, index is the row
	string rowName [0:maxRows-1];
	actT rowAct [0:maxRows-1];
	int rowSteps [0:maxRows-1]; // ticks in a run, or random probes
	int rowX [0:maxRows-1]; // head x, or pixel row on a probe
	int rowY [0:maxRows-1];
	bit rowOnHead [0:maxRows-1]; // food follows the head
	int rowFoodX [0:maxRows-1];
	int rowFoodY [0:maxRows-1];
	int rowLen [0:maxRows-1];
	int rowFood [0:maxRows-1]; // foodGen one cycle after the tick
	int rowOver [0:maxRows-1];
	int rowIcon [0:maxRows-1];
	int numRows;
	int stepTotal;
	bit tableReady;

	// reference body from the move rules, only steers random probes
	int modelX [0:modelMax];
	int modelY [0:modelMax];
	int modelLen;

	int checks;
	int errors;
	integer seed;

	always #(periodNs / 2) Clock = ~Clock;

	snakeTop i_snakeTop (
		.Clock(Clock),
		.rstN(rstN),
		.ctrlOff(ctrlOff),
		.iconTick(iconTick),
		.pixelRow(pixelRow),
		.pixelCol(pixelCol),
		.locationX(locationX),
		.locationY(locationY),
		.foodX(foodX),
		.foodY(foodY),
		.icon(icon),
		.snakeLength(snakeLength),
		.gameOver(gameOver),
		.foodGen(foodGen)
	);

	task automatic addRow(input string name, input actT act, input int steps, input int x,
		input int y, input bit onHead, input int fx, input int fy, input int expLen,
		input int expFood, input int expOver, input int expIcon);
		rowName[numRows] = name;
		rowAct[numRows] = act;
		rowSteps[numRows] = steps;
		rowX[numRows] = x;
		rowY[numRows] = y;
		rowOnHead[numRows] = onHead;
		rowFoodX[numRows] = fx;
		rowFoodY[numRows] = fy;
		rowLen[numRows] = expLen;
		rowFood[numRows] = expFood;
		rowOver[numRows] = expOver;
		rowIcon[numRows] = expIcon;
		stepTotal += steps; // sizes the watchdog
		numRows++;
	endtask

	`include "snakeTbTable.svh"

	task automatic reportMismatch(input string name, input string what, input int expected,
		input logic [31:0] actual);
		errors++;
		$display("error %s: %s expected %0d, actual %0d", name, what, expected, actual);
	endtask

	// length after one eat, jumps at the level ends
	function automatic int grownLength(input int len);
		if (len == int'(levelOneEnd))
			return int'(levelTwoStart);
		if (len == int'(levelTwoEnd))
			return int'(levelThreeStart);
		return len + 1;
	endfunction

	task automatic resetModel();
		for (int i = 0; i <= modelMax; i++)
		begin
			modelX[i] = (i <= int'(startLength)) ? int'(startX) - i : 0;
			modelY[i] = (i <= int'(startLength)) ? int'(startY) : 0;
		end
		modelLen = int'(startLength);
	endtask

	task automatic shiftModel(input int x, input int y, input bit eat);
		for (int i = modelMax; i >= 1; i--)
		begin
			modelX[i] = (i <= modelLen) ? modelX[i-1] : 0; // top down, old values
			modelY[i] = (i <= modelLen) ? modelY[i-1] : 0;
		end
		modelX[0] = x;
		modelY[0] = y;
		if (eat)
			modelLen = grownLength(modelLen); // shift used the old length
	endtask

	function automatic bit onModelBody(input int x, input int y);
		for (int i = 0; i <= modelLen; i++)
		begin
			if ((modelX[i] == x) && (modelY[i] == y))
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// length and game over, read after the collision stage settled
	task automatic checkState(input int r);
		checks += 2;
		if (snakeLength !== lengthT'(rowLen[r]))
			reportMismatch(rowName[r], "snakeLength", rowLen[r], snakeLength);
		if (gameOver !== (rowOver[r] != 0))
			reportMismatch(rowName[r], "gameOver", rowOver[r], gameOver);
	endtask

	task automatic resetDut(input int r);
		@(posedge Clock);
		#2;
		rstN = 1'b0;
		iconTick = 1'b0;
		ctrlOff = 1'b0;
		pixelRow = '0; // pixel off the start body
		pixelCol = '0;
		repeat (2) @(posedge Clock);
		@(negedge Clock);
		checks++;
		if (foodGen !== 1'b1)
			reportMismatch(rowName[r], "foodGen during reset", 1, foodGen);
		@(posedge Clock); // third cycle low
		#2;
		rstN = 1'b1;
		@(posedge Clock);
		@(negedge Clock);
		checkState(r);
		checks += 2;
		if (foodGen !== (rowFood[r] != 0))
			reportMismatch(rowName[r], "foodGen", rowFood[r], foodGen);
		if (icon !== iconT'(rowIcon[r]))
			reportMismatch(rowName[r], "icon", rowIcon[r], icon);
	endtask

	// one move, k is the place within a run
	task automatic tickStep(input int r, input int k, input bit frozen);
		int x;
		int y;
		int fx;
		int fy;
		x = rowX[r] + k;
		y = rowY[r];
		fx = rowOnHead[r] ? x : rowFoodX[r];
		fy = rowOnHead[r] ? y : rowFoodY[r];
		@(posedge Clock);
		#2;
		locationX = coordT'(x);
		locationY = coordT'(y);
		foodX = coordT'(fx);
		foodY = coordT'(fy);
		ctrlOff = frozen;
		iconTick = 1'b1;
		@(posedge Clock);
		#2;
		iconTick = 1'b0; // one cycle strobe
		ctrlOff = 1'b0;
		if (!frozen)
			shiftModel(x, y, (x == fx) && (y == fy));
		@(negedge Clock);
		checks++;
		if (foodGen !== (rowFood[r] != 0))
			reportMismatch(rowName[r], "foodGen", rowFood[r], foodGen);
		repeat (2) @(posedge Clock); // game over lands on the second edge
		@(negedge Clock);
		checks++;
		if (foodGen !== 1'b0)
			reportMismatch(rowName[r], "foodGen after one cycle", 0, foodGen); // request is a pulse
		if (k == rowSteps[r] - 1)
			checkState(r); // end of the run only
	endtask

	task automatic probeStep(input int r, input int x, input int y);
		@(posedge Clock);
		#2;
		pixelRow = coordT'(x);
		pixelCol = coordT'(y);
		@(posedge Clock); // icon registered here
		@(negedge Clock);
		checks++;
		if (icon !== iconT'(rowIcon[r]))
			reportMismatch(rowName[r], "icon", rowIcon[r], icon);
	endtask

	// pixel strictly inside the walls
	task automatic randomProbe(input int r);
		int x;
		int y;
		x = int'(xMin) + 1 + ($unsigned($random(seed)) % 256);
		y = int'(yMin) + 1 + ($unsigned($random(seed)) % 255);
		if (onModelBody(x, y))
			$display("note %s: random pixel (%0d,%0d) is on the body, skipped", rowName[r], x, y);
		else
			probeStep(r, x, y);
	endtask

	initial
	begin
		Clock = 1'b0;
		rstN = 1'b0;
		ctrlOff = 1'b0;
		iconTick = 1'b0;
		pixelRow = '0;
		pixelCol = '0;
		locationX = startX;
		locationY = startY;
		foodX = 11'd300;
		foodY = 11'd300;
		seed = 62;
		checks = 0;
		errors = 0;
		numRows = 0;
		stepTotal = 0;
		resetModel();
		loadTable();
		tableReady = 1'b1;
		for (int r = 0; r < numRows; r++)
		begin
			case (rowAct[r])
				actReset:
				begin
					resetDut(r);
					resetModel();
				end
				actTick, actFrozen:
				begin
					for (int k = 0; k < rowSteps[r]; k++)
						tickStep(r, k, rowAct[r] == actFrozen);
				end
				actProbe:
					probeStep(r, rowX[r], rowY[r]);
				default:
				begin
					for (int k = 0; k < rowSteps[r]; k++)
						randomProbe(r);
				end
			endcase
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// about five cycles per step, plus slack
	initial
	begin
		wait (tableReady);
		#((stepTotal * 5 + 10) * periodNs);
		$display("timeout: run did not finish within %0d steps", stepTotal);
		$display("TESTS FAILED");
		$finish;
	end

endmodule
